// ==== dv/vga_text_model.svh ====
`ifndef VGA_TEXT_MODEL_SVH
`define VGA_TEXT_MODEL_SVH

// shadow copies of everything the bus has written
logic [char_bits-1:0]  text_shadow [0:(1 << text_addr_bits)-1];
logic [glyph_w-1:0]    font_shadow [0:(1 << font_addr_bits)-1];
logic [color_bits-1:0] fg_shadow = 24'hff_ffff;
logic [color_bits-1:0] bg_shadow = 24'h00_0000;

function automatic logic in_visible_area(input int h, input int v);
	return (h < h_visible) && (v < v_visible);
endfunction

// both syncs are active low
function automatic logic hsync_level(input int h);
	return !((h >= h_visible + h_front) && (h < h_visible + h_front + h_sync));
endfunction

function automatic logic vsync_level(input int v);
	return !((v >= v_visible + v_front) && (v < v_visible + v_front + v_sync));
endfunction

// text address is row above column, glyph bit 8 is the leftmost pixel
function automatic logic [color_bits-1:0] pixel_color(input int h, input int v);
	int                   taddr;
	logic [char_bits-1:0] code;
	logic [glyph_w-1:0]   glyph;
	if (!in_visible_area(h, v)) begin
		return '0;
	end
	taddr = (v / cell_h) * (1 << col_bits) + h / cell_w;
	code  = text_shadow[taddr];
	glyph = font_shadow[int'(code) * cell_h + v % cell_h];
	return glyph[glyph_w - 1 - h % cell_w] ? fg_shadow : bg_shadow;
endfunction

function automatic logic [wb_data_bits-1:0] read_value(input logic [wb_adr_bits-1:0] adr);
	case (adr[13:12])
		region_text:  return wb_data_bits'(text_shadow[adr[11:0]]);
		region_font:  return wb_data_bits'(font_shadow[adr[11:0]]);
		region_color: return wb_data_bits'(adr[0] ? bg_shadow : fg_shadow);
		default:      return '0;
	endcase
endfunction

// region 3 drops the write
function automatic void store_shadow(input logic [wb_adr_bits-1:0] adr, input logic [31:0] data);
	case (adr[13:12])
		region_text:  text_shadow[adr[11:0]] = data[char_bits-1:0];
		region_font:  font_shadow[adr[11:0]] = data[glyph_w-1:0];
		region_color: begin
			if (adr[0]) begin
				bg_shadow = data[color_bits-1:0];
			end else begin
				fg_shadow = data[color_bits-1:0];
			end
		end
		default: ;
	endcase
endfunction

`endif

// ==== dv/vga_text_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_text_tb
	import vga_text_pkg::*;
();

	localparam int frame_clocks = h_total * v_total;
	localparam int ack_timeout  = 16;

	logic                    clk = 1'b0;
	logic                    rst_n = 1'b0;
	logic                    wb_cyc = 1'b0;
	logic                    wb_stb = 1'b0;
	logic                    wb_we = 1'b0;
	logic [wb_adr_bits-1:0]  wb_adr = '0;
	logic [wb_data_bits-1:0] wb_dat_w = '0;
	logic [wb_data_bits-1:0] wb_dat_r;
	logic                    wb_ack;
	logic                    vga_hsync;
	logic                    vga_vsync;
	logic                    vga_blank_n;
	logic [7:0]              vga_r;
	logic [7:0]              vga_g;
	logic [7:0]              vga_b;

	logic [31:0] lfsr_state = 32'hcdca_5939;
	int          clk_count = 0;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errors_at_start = 0;
	int          checks_at_start = 0;
	string       current_test = "";

	`include "vga_text_model.svh"

	vga_text_top i_vga_text_top (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank_n(vga_blank_n),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	always #50 clk = ~clk;

	// clocks since reset release, the pins lag this by pix_latency
	always @(posedge clk) begin
		if (!rst_n) begin
			clk_count <= 0;
		end else begin
			clk_count <= clk_count + 1;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	task automatic start_test(input string name);
		current_test    = name;
		errors_at_start = errors;
		checks_at_start = checks;
	endtask

	task automatic end_test();
		int test_errors;
		test_errors = errors - errors_at_start;
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %s %s: %0d checks, %0d errors", current_test,
			(test_errors == 0) ? "ok" : "failed", checks - checks_at_start, test_errors);
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR in %s: %s", current_test, msg);
		errors++;
	endtask

	task automatic expect_equal(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			$display("FAIL %s %s: expected 0x%0h actual 0x%0h", current_test, what,
				expected, actual);
			errors++;
		end
	endtask

	// one classic cycle, signals held until ack, ack must drop after one clock
	task automatic single_transfer(input logic we, input logic [wb_adr_bits-1:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int   waited;
		logic got_ack;
		waited  = 0;
		got_ack = 1'b0;
		rdata   = '0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdata;
		while (!got_ack && waited < ack_timeout) begin
			@(negedge clk);
			waited++;
			if (wb_ack) begin
				got_ack = 1'b1;
				rdata   = wb_dat_r;
			end
		end
		assert (got_ack) else report_problem($sformatf("no ack within %0d cycles at 0x%0h",
			ack_timeout, adr));
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk);
		expect_equal("ack one cycle wide", 0, wb_ack);
	endtask

	task automatic write_word(input logic [wb_adr_bits-1:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		single_transfer(1'b1, adr, data, unused);
		store_shadow(adr, data);
	endtask

	task automatic read_word(input logic [wb_adr_bits-1:0] adr, output logic [31:0] data);
		single_transfer(1'b0, adr, '0, data);
	endtask

	task automatic compare_pixel(input int h, input int v);
		logic [color_bits-1:0] rgb;
		logic [color_bits-1:0] exp_rgb;
		rgb     = {vga_r, vga_g, vga_b};
		exp_rgb = pixel_color(h, v);
		checks += 4;
		assert (rgb === exp_rgb) else begin
			$display("FAIL %s rgb at (%0d,%0d): expected 0x%06h actual 0x%06h",
				current_test, h, v, exp_rgb, rgb);
			errors++;
		end
		assert (vga_hsync === hsync_level(h)) else begin
			$display("FAIL %s hsync at (%0d,%0d): expected %0b actual %0b",
				current_test, h, v, hsync_level(h), vga_hsync);
			errors++;
		end
		assert (vga_vsync === vsync_level(v)) else begin
			$display("FAIL %s vsync at (%0d,%0d): expected %0b actual %0b",
				current_test, h, v, vsync_level(v), vga_vsync);
			errors++;
		end
		assert (vga_blank_n === in_visible_area(h, v)) else begin
			$display("FAIL %s blank_n at (%0d,%0d): expected %0b actual %0b",
				current_test, h, v, in_visible_area(h, v), vga_blank_n);
			errors++;
		end
	endtask

	// waits for pixel 0 of line 0 at the pins, then compares one whole frame
	task automatic frame_matches();
		int   waited;
		int   p;
		logic found;
		waited = 0;
		found  = 1'b0;
		while (!found && waited < 2 * frame_clocks) begin
			@(negedge clk);
			waited++;
			p     = clk_count - pix_latency;
			found = (p >= 0) && (p % frame_clocks == 0);
		end
		assert (found) else report_problem("no frame start seen at the pins");
		if (found) begin
			for (int v = 0; v < v_total; v++) begin
				for (int h = 0; h < h_total; h++) begin
					compare_pixel(h, v);
					@(negedge clk);
				end
			end
		end
	endtask

	task automatic reset_values();
		logic [31:0] data;
		start_test("reset");
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			if (i == 4) begin
				rst_n <= 1'b1;
			end
			@(negedge clk);
			expect_equal("hsync in reset", 1, vga_hsync);
			expect_equal("vsync in reset", 1, vga_vsync);
			expect_equal("blank_n in reset", 0, vga_blank_n);
			expect_equal("colour in reset", 0, {vga_r, vga_g, vga_b});
		end
		read_word({region_color, 12'h000}, data);
		expect_equal("fg after reset", 32'h00ff_ffff, data);
		read_word({region_color, 12'h001}, data);
		expect_equal("bg after reset", 32'h0000_0000, data);
		end_test();
	endtask

	task automatic bus_roundtrip();
		logic [wb_adr_bits-1:0] adrs [$];
		logic [wb_adr_bits-1:0] adr;
		logic [31:0]            data;
		start_test("bus_roundtrip");
		// about a quarter land in region 3 and must read zero
		for (int i = 0; i < 200; i++) begin
			adr = wb_adr_bits'(random_bits(wb_adr_bits));
			write_word(adr, random_bits(32));
			adrs.push_back(adr);
			repeat (int'(random_bits(2))) @(posedge clk);
		end
		foreach (adrs[k]) begin
			read_word(adrs[k], data);
			expect_equal($sformatf("read 0x%0h", adrs[k]), read_value(adrs[k]), data);
			repeat (int'(random_bits(2))) @(posedge clk);
		end
		end_test();
	endtask

	task automatic sync_shape();
		int   waited;
		logic found;
		logic seen_vs;
		logic prev_vs;
		logic prev_blank;
		int   hi_cnt;
		int   hi_last;
		int   hs_cnt;
		int   hs_first;
		int   vis_lines;
		int   vs_lines;
		int   vs_first;
		start_test("sync_shape");
		waited     = 0;
		found      = 1'b0;
		seen_vs    = 1'b0;
		prev_vs    = vga_vsync;
		prev_blank = vga_blank_n;
		vis_lines  = 0;
		vs_lines   = 0;
		vs_first   = -1;
		// end of a vsync pulse, then the blank_n rise that opens the next frame
		while (!found && waited < 3 * frame_clocks) begin
			@(negedge clk);
			waited++;
			if (vga_vsync && !prev_vs) begin
				seen_vs = 1'b1;
			end
			if (seen_vs && vga_blank_n && !prev_blank) begin
				found = 1'b1;
			end
			prev_vs    = vga_vsync;
			prev_blank = vga_blank_n;
		end
		assert (found) else report_problem("blank_n never rose after a vsync pulse");
		if (found) begin
			for (int v = 0; v < v_total; v++) begin
				hi_cnt   = 0;
				hi_last  = -1;
				hs_cnt   = 0;
				hs_first = -1;
				for (int h = 0; h < h_total; h++) begin
					if (vga_blank_n) begin
						hi_cnt++;
						hi_last = h;
					end
					if (!vga_hsync) begin
						hs_cnt++;
						if (hs_first < 0) begin
							hs_first = h;
						end
					end
					if (h == 0 && !vga_vsync) begin
						vs_lines++;
						if (vs_first < 0) begin
							vs_first = v;
						end
					end
					@(negedge clk);
				end
				if (hi_cnt > 0) begin
					vis_lines++;
					expect_equal($sformatf("last visible clock, line %0d", v), h_visible - 1,
						hi_last);
				end
				expect_equal($sformatf("blank_n high clocks, line %0d", v),
					(v < v_visible) ? h_visible : 0, hi_cnt);
				expect_equal($sformatf("hsync low clocks, line %0d", v), h_sync, hs_cnt);
				expect_equal($sformatf("hsync low start, line %0d", v), h_visible + h_front,
					hs_first);
			end
		end
		expect_equal("visible lines", v_visible, vis_lines);
		expect_equal("vsync low lines", v_sync, vs_lines);
		expect_equal("vsync first line", v_visible + v_front, vs_first);
		end_test();
	endtask

	task automatic render_frame();
		start_test("render");
		for (int a = 0; a < (1 << font_addr_bits); a++) begin
			write_word({region_font, 12'(a)}, random_bits(glyph_w));
		end
		for (int row = 0; row < text_rows; row++) begin
			for (int col = 0; col < text_cols; col++) begin
				write_word({region_text, 5'(row), 7'(col)}, random_bits(char_bits));
			end
		end
		// column 639 falls in cell 71, which is one pixel wide
		frame_matches();
		end_test();
	endtask

	task automatic color_change();
		int   waited;
		int   line;
		logic found;
		start_test("color_change");
		waited = 0;
		found  = 1'b0;
		while (!found && waited < 2 * frame_clocks) begin
			@(negedge clk);
			waited++;
			line  = ((clk_count - pix_latency) / h_total) % v_total;
			found = (clk_count >= pix_latency) && (line > v_visible) &&
				(line < v_visible + 20);
		end
		assert (found) else report_problem("vertical blanking never reached");
		write_word({region_color, 12'h000}, random_bits(color_bits));
		write_word({region_color, 12'h001}, random_bits(color_bits));
		frame_matches();
		end_test();
	endtask

	initial begin
		reset_values();
		bus_roundtrip();
		sync_shape();
		render_frame();
		color_change();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/glyph_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module glyph_fetch
	import vga_text_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      font_we,
	input  logic [font_addr_bits-1:0] bus_addr,
	input  logic [glyph_w-1:0]        bus_wdata,
	output logic [glyph_w-1:0]        font_rdata,
	input  logic [char_bits-1:0]      char_code,
	input  logic [cell_x_bits-1:0]    s1_x,
	input  logic [cell_y_bits-1:0]    s1_y,
	input  logic                      s1_hsync,
	input  logic                      s1_vsync,
	input  logic                      s1_visible,
	output logic                      pix_on,
	output logic                      s2_hsync,
	output logic                      s2_vsync,
	output logic                      s2_visible
);

	// 256 glyphs, 16 rows each
	logic [glyph_w-1:0]     font_mem [0:(1 << font_addr_bits)-1];
	logic [glyph_w-1:0]     glyph_row;
	logic [cell_x_bits-1:0] x_q;
	logic [cell_x_bits-1:0] bit_idx;

	// port A, bus side
	always_ff @(posedge clk) begin
		if (font_we) begin
			font_mem[bus_addr] <= bus_wdata;
		end
		font_rdata <= font_mem[bus_addr];
	end

	// port B, glyph row for this character line
	always_ff @(posedge clk) begin
		glyph_row <= font_mem[{char_code, s1_y}];
		x_q       <= s1_x;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_hsync   <= 1'b1;
			s2_vsync   <= 1'b1;
			s2_visible <= 1'b0;
		end else begin
			s2_hsync   <= s1_hsync;
			s2_vsync   <= s1_vsync;
			s2_visible <= s1_visible;
		end
	end

	// bit 8 is the leftmost pixel of the cell
	assign bit_idx = cell_x_bits'(glyph_w - 1) - x_q;
	assign pix_on  = glyph_row[bit_idx];

endmodule

`default_nettype wire

// ==== hw/pixel_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_out
	import vga_text_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pix_on,
	input  logic                  s2_hsync,
	input  logic                  s2_vsync,
	input  logic                  s2_visible,
	input  logic [color_bits-1:0] fg_color,
	input  logic [color_bits-1:0] bg_color,
	output logic                  vga_hsync,
	output logic                  vga_vsync,
	output logic                  vga_blank_n,
	output logic [7:0]            vga_r,
	output logic [7:0]            vga_g,
	output logic [7:0]            vga_b
);

	logic [color_bits-1:0] color;

	// black during blanking
	always_comb begin
		if (!s2_visible) begin
			color = '0;
		end else if (pix_on) begin
			color = fg_color;
		end else begin
			color = bg_color;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vga_hsync   <= 1'b1;
			vga_vsync   <= 1'b1;
			vga_blank_n <= 1'b0;
			vga_r       <= '0;
			vga_g       <= '0;
			vga_b       <= '0;
		end else begin
			vga_hsync   <= s2_hsync;
			vga_vsync   <= s2_vsync;
			vga_blank_n <= s2_visible;
			vga_r       <= color[23:16];
			vga_g       <= color[15:8];
			vga_b       <= color[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/text_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module text_fetch
	import vga_text_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      text_we,
	input  logic [text_addr_bits-1:0] bus_addr,
	input  logic [char_bits-1:0]      bus_wdata,
	output logic [char_bits-1:0]      text_rdata,
	input  logic [col_bits-1:0]       cell_col,
	input  logic [row_bits-1:0]       cell_row,
	input  logic [cell_x_bits-1:0]    cell_x,
	input  logic [cell_y_bits-1:0]    cell_y,
	input  logic                      hsync_raw,
	input  logic                      vsync_raw,
	input  logic                      visible,
	output logic [char_bits-1:0]      char_code,
	output logic [cell_x_bits-1:0]    s1_x,
	output logic [cell_y_bits-1:0]    s1_y,
	output logic                      s1_hsync,
	output logic                      s1_vsync,
	output logic                      s1_visible
);

	// one character code per cell
	logic [char_bits-1:0] text_mem [0:(1 << text_addr_bits)-1];

	// port A, bus side
	always_ff @(posedge clk) begin
		if (text_we) begin
			text_mem[bus_addr] <= bus_wdata;
		end
		text_rdata <= text_mem[bus_addr];
	end

	// port B, pixel side
	always_ff @(posedge clk) begin
		char_code <= text_mem[{cell_row, cell_col}];
		s1_x      <= cell_x;
		s1_y      <= cell_y;
	end

	// flags follow the code by one stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_hsync   <= 1'b1;
			s1_vsync   <= 1'b1;
			s1_visible <= 1'b0;
		end else begin
			s1_hsync   <= hsync_raw;
			s1_vsync   <= vsync_raw;
			s1_visible <= visible;
		end
	end

endmodule

`default_nettype wire

// ==== hw/vga_text_pkg.sv ====
`default_nettype none

package vga_text_pkg;

	// horizontal timing in pixels
	localparam int h_visible = 640;
	localparam int h_front   = 16;
	localparam int h_sync    = 96;
	localparam int h_back    = 48;
	localparam int h_total   = h_visible + h_front + h_sync + h_back;

	// vertical timing in lines
	localparam int v_visible = 480;
	localparam int v_front   = 10;
	localparam int v_sync    = 2;
	localparam int v_back    = 33;
	localparam int v_total   = v_visible + v_front + v_sync + v_back;

	localparam int h_bits = $clog2(h_total);
	localparam int v_bits = $clog2(v_total);

	// character cells, last column is a single pixel wide
	localparam int cell_w      = 9;
	localparam int cell_h      = 16;
	localparam int cell_x_bits = $clog2(cell_w);
	localparam int cell_y_bits = $clog2(cell_h);
	localparam int text_cols   = (h_visible + cell_w - 1) / cell_w;
	localparam int text_rows   = v_visible / cell_h;
	localparam int col_bits    = $clog2(text_cols);
	localparam int row_bits    = $clog2(text_rows);
	localparam int char_bits   = 8;
	localparam int glyph_w     = 9;

	// text address is {row, col}, font address is {code, glyph row}
	localparam int text_addr_bits = row_bits + col_bits;
	localparam int font_addr_bits = char_bits + cell_y_bits;

	localparam int pix_latency  = 3;
	localparam int wb_adr_bits  = 14;
	localparam int wb_data_bits = 32;

	// bus regions on adr[13:12]
	localparam logic [1:0] region_text  = 2'd0;
	localparam logic [1:0] region_font  = 2'd1;
	localparam logic [1:0] region_color = 2'd2;
	localparam logic [1:0] region_none  = 2'd3;

	// colours are {r, g, b}
	localparam int                    color_bits = 24;
	localparam logic [color_bits-1:0] fg_reset   = 24'hff_ffff;
	localparam logic [color_bits-1:0] bg_reset   = 24'h00_0000;

endpackage

`default_nettype wire

// ==== hw/vga_text_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_text_top
	import vga_text_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [wb_adr_bits-1:0]  wb_adr,
	input  logic [wb_data_bits-1:0] wb_dat_w,
	output logic [wb_data_bits-1:0] wb_dat_r,
	output logic                    wb_ack,
	output logic                    vga_hsync,
	output logic                    vga_vsync,
	output logic                    vga_blank_n,
	output logic [7:0]              vga_r,
	output logic [7:0]              vga_g,
	output logic [7:0]              vga_b
);

	logic                      text_we;
	logic                      font_we;
	logic [text_addr_bits-1:0] bus_addr;
	logic [glyph_w-1:0]        bus_wdata;
	logic [char_bits-1:0]      text_rdata;
	logic [glyph_w-1:0]        font_rdata;
	logic [color_bits-1:0]     fg_color;
	logic [color_bits-1:0]     bg_color;

	logic [col_bits-1:0]    cell_col;
	logic [row_bits-1:0]    cell_row;
	logic [cell_x_bits-1:0] cell_x;
	logic [cell_y_bits-1:0] cell_y;
	logic                   hsync_raw;
	logic                   vsync_raw;
	logic                   visible;

	logic [char_bits-1:0]   char_code;
	logic [cell_x_bits-1:0] s1_x;
	logic [cell_y_bits-1:0] s1_y;
	logic                   s1_hsync;
	logic                   s1_vsync;
	logic                   s1_visible;

	logic pix_on;
	logic s2_hsync;
	logic s2_vsync;
	logic s2_visible;

	wb_regs i_wb_regs (
		.clk(clk), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.text_we(text_we), .font_we(font_we),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.text_rdata(text_rdata), .font_rdata(font_rdata),
		.fg_color(fg_color), .bg_color(bg_color)
	);

	vga_timing i_vga_timing (
		.clk(clk), .rst_n(rst_n),
		.cell_col(cell_col), .cell_row(cell_row), .cell_x(cell_x), .cell_y(cell_y),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .visible(visible)
	);

	text_fetch i_text_fetch (
		.clk(clk), .rst_n(rst_n),
		.text_we(text_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata[char_bits-1:0]),
		.text_rdata(text_rdata),
		.cell_col(cell_col), .cell_row(cell_row), .cell_x(cell_x), .cell_y(cell_y),
		.hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .visible(visible),
		.char_code(char_code), .s1_x(s1_x), .s1_y(s1_y),
		.s1_hsync(s1_hsync), .s1_vsync(s1_vsync), .s1_visible(s1_visible)
	);

	glyph_fetch i_glyph_fetch (
		.clk(clk), .rst_n(rst_n),
		.font_we(font_we), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.font_rdata(font_rdata),
		.char_code(char_code), .s1_x(s1_x), .s1_y(s1_y),
		.s1_hsync(s1_hsync), .s1_vsync(s1_vsync), .s1_visible(s1_visible),
		.pix_on(pix_on), .s2_hsync(s2_hsync), .s2_vsync(s2_vsync), .s2_visible(s2_visible)
	);

	pixel_out i_pixel_out (
		.clk(clk), .rst_n(rst_n),
		.pix_on(pix_on), .s2_hsync(s2_hsync), .s2_vsync(s2_vsync), .s2_visible(s2_visible),
		.fg_color(fg_color), .bg_color(bg_color),
		.vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_blank_n(vga_blank_n),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

endmodule

`default_nettype wire

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_timing
	import vga_text_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	output logic [col_bits-1:0]    cell_col,
	output logic [row_bits-1:0]    cell_row,
	output logic [cell_x_bits-1:0] cell_x,
	output logic [cell_y_bits-1:0] cell_y,
	output logic                   hsync_raw,
	output logic                   vsync_raw,
	output logic                   visible
);

	logic [h_bits-1:0] h_cnt;
	logic [v_bits-1:0] v_cnt;
	logic              line_end;
	logic              frame_end;

	assign line_end  = (h_cnt == h_bits'(h_total - 1));
	assign frame_end = line_end && (v_cnt == v_bits'(v_total - 1));

	// raw pixel and line position
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (line_end) begin
				h_cnt <= '0;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
			if (frame_end) begin
				v_cnt <= '0;
			end else if (line_end) begin
				v_cnt <= v_cnt + 1'b1;
			end
		end
	end

	// column and pixel-in-cell restart every line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cell_x   <= '0;
			cell_col <= '0;
		end else if (line_end) begin
			cell_x   <= '0;
			cell_col <= '0;
		end else if (cell_x == cell_x_bits'(cell_w - 1)) begin
			cell_x   <= '0;
			cell_col <= cell_col + 1'b1;
		end else begin
			cell_x <= cell_x + 1'b1;
		end
	end

	// row and line-in-cell step once per line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cell_y   <= '0;
			cell_row <= '0;
		end else if (frame_end) begin
			cell_y   <= '0;
			cell_row <= '0;
		end else if (line_end) begin
			if (cell_y == cell_y_bits'(cell_h - 1)) begin
				cell_y   <= '0;
				cell_row <= cell_row + 1'b1;
			end else begin
				cell_y <= cell_y + 1'b1;
			end
		end
	end

	// syncs are active low
	assign hsync_raw = !((h_cnt >= h_bits'(h_visible + h_front)) &&
		(h_cnt < h_bits'(h_visible + h_front + h_sync)));
	assign vsync_raw = !((v_cnt >= v_bits'(v_visible + v_front)) &&
		(v_cnt < v_bits'(v_visible + v_front + v_sync)));
	assign visible   = (h_cnt < h_bits'(h_visible)) && (v_cnt < v_bits'(v_visible));

	cell_x_range: assert property (@(posedge clk) disable iff (!rst_n)
		cell_x < cell_x_bits'(cell_w));
	// incremental row tracking must agree with v_cnt / 16 on visible lines
	cell_row_sync: assert property (@(posedge clk) disable iff (!rst_n)
		(v_cnt < v_bits'(v_visible)) |->
		((int'(cell_row) * cell_h + int'(cell_y)) == int'(v_cnt)));
	// incremental column tracking must agree with h_cnt / 9
	cell_col_sync: assert property (@(posedge clk) disable iff (!rst_n)
		(int'(cell_col) * cell_w + int'(cell_x)) == int'(h_cnt));

endmodule

`default_nettype wire

// ==== hw/wb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_regs
	import vga_text_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  logic [wb_adr_bits-1:0]    wb_adr,
	input  logic [wb_data_bits-1:0]   wb_dat_w,
	output logic [wb_data_bits-1:0]   wb_dat_r,
	output logic                      wb_ack,
	output logic                      text_we,
	output logic                      font_we,
	output logic [text_addr_bits-1:0] bus_addr,
	output logic [glyph_w-1:0]        bus_wdata,
	input  logic [char_bits-1:0]      text_rdata,
	input  logic [glyph_w-1:0]        font_rdata,
	output logic [color_bits-1:0]     fg_color,
	output logic [color_bits-1:0]     bg_color
);

	logic [1:0] region;
	logic       req;
	logic [1:0] rd_region;
	logic       rd_bg;

	assign region = wb_adr[wb_adr_bits-1 -: 2];
	// new request only while ack is low
	assign req    = wb_cyc && wb_stb && !wb_ack;

	// RAM port A driven straight from the bus
	assign bus_addr  = wb_adr[text_addr_bits-1:0];
	assign bus_wdata = wb_dat_w[glyph_w-1:0];
	assign text_we   = req && wb_we && (region == region_text);
	assign font_we   = req && wb_we && (region == region_font);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= req;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fg_color <= fg_reset;
			bg_color <= bg_reset;
		end else if (req && wb_we && (region == region_color)) begin
			if (wb_adr[0]) begin
				bg_color <= wb_dat_w[color_bits-1:0];
			end else begin
				fg_color <= wb_dat_w[color_bits-1:0];
			end
		end
	end

	// remember what the ack cycle returns
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_region <= region_none;
			rd_bg     <= 1'b0;
		end else if (req) begin
			rd_region <= region;
			rd_bg     <= wb_adr[0];
		end
	end

	always_comb begin
		wb_dat_r = '0;
		case (rd_region)
			region_text:  wb_dat_r[char_bits-1:0]  = text_rdata;
			region_font:  wb_dat_r[glyph_w-1:0]    = font_rdata;
			region_color: wb_dat_r[color_bits-1:0] = rd_bg ? bg_color : fg_color;
			default:      wb_dat_r = '0;
		endcase
	end

	// master holds cyc and stb until it sees ack
	ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb));
	// address, direction and write data stay put through the ack cycle
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		req |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_w)));

endmodule

`default_nettype wire

// ==== vga_text.f ====
+incdir+dv
hw/vga_text_pkg.sv
hw/vga_timing.sv
hw/wb_regs.sv
hw/text_fetch.sv
hw/glyph_fetch.sv
hw/pixel_out.sv
hw/vga_text_top.sv
dv/vga_text_tb.sv
